// File: files.f
logic/gprPkg.sv
logic/laneResultIf.sv
logic/gprBankArray.sv
logic/sprRegister.sv
logic/operandPort.sv
logic/gprFile.sv
tb/gprFileTb.sv

// File: tb/gprFileTb.sv
/*
  Directed testbench for the operand register file
  - reference model of the GPRs and DLR/DHR/SP
  - xorshift data source, compare tasks, cycle limit
  - write-back, lane conflict, forwarding, special and constant tests
*/
`timescale 1ns/1ns

module gprFileTb;
	import gprPkg::*;

	localparam int cycleLimit = 2000;	// Tests run about 90 cycles

	logic clock;
	logic rstN;
	logic hold;
	logic ex3Flush;
	regIdT srcId [numReadPorts];	// Rs, Rt, Ru, Rv, Rx, Ry
	regIdT exId [3][numLanes];	// Stage, lane
	regValT exVal [3][numLanes];
	addrValT pc, gbr, lr;
	immValT imm [numLanes];
	regValT inSpr [3];	// DLR, DHR, SP inputs
	regValT valRs, valRt, valRu, valRv, valRx, valRy;
	regValT outDlr, outDhr, outSp;

	regValT refGpr [numGprs];	// Reference model
	regValT refSpr [3];
	regIdT sprCode [3];
	logic [63:0] randState = 64'd90207;
	int cycleCount = 0;

	gprFile i_gprFile(
		.clock(clock), .rstN(rstN), .hold(hold), .ex3Flush(ex3Flush),
		.idRs(srcId[0]), .idRt(srcId[1]), .idRu(srcId[2]),
		.idRv(srcId[3]), .idRx(srcId[4]), .idRy(srcId[5]),
		.valRs(valRs), .valRt(valRt), .valRu(valRu),
		.valRv(valRv), .valRx(valRx), .valRy(valRy),
		.ex1IdA(exId[0][0]), .ex1IdB(exId[0][1]), .ex1IdC(exId[0][2]),
		.ex1ValA(exVal[0][0]), .ex1ValB(exVal[0][1]), .ex1ValC(exVal[0][2]),
		.ex2IdA(exId[1][0]), .ex2IdB(exId[1][1]), .ex2IdC(exId[1][2]),
		.ex2ValA(exVal[1][0]), .ex2ValB(exVal[1][1]), .ex2ValC(exVal[1][2]),
		.ex3IdA(exId[2][0]), .ex3IdB(exId[2][1]), .ex3IdC(exId[2][2]),
		.ex3ValA(exVal[2][0]), .ex3ValB(exVal[2][1]), .ex3ValC(exVal[2][2]),
		.pc(pc), .gbr(gbr), .lr(lr),
		.immA(imm[0]), .immB(imm[1]), .immC(imm[2]),
		.inDlr(inSpr[0]), .inDhr(inSpr[1]), .inSp(inSpr[2]),
		.outDlr(outDlr), .outDhr(outDhr), .outSp(outSp)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [63:0] nextRand();
		randState = randState ^ (randState << 13);
		randState = randState ^ (randState >> 7);
		randState = randState ^ (randState << 17);
		return randState;
	endfunction

	// Expected read value: newest stage result, else the decoded source
	function automatic regValT refRead(input int p);
		regIdT src;
		src = srcId[p];
		if (src != idImm && src != idZzr)
			for (int s = 0; s < 3; s++)
				for (int l = 0; l < numLanes; l++)
					if (exId[s][l] == src)
						return exVal[s][l];
		if (!src[5])
			return refGpr[src[4:0]];
		case (src)
			idDlr: return refSpr[0];
			idDhr: return refSpr[1];
			idSp: return refSpr[2];
			idPc: return regValT'(pc);
			idGbr: return regValT'(gbr);
			idLr: return regValT'(lr);
			idImm: return regValT'($signed(imm[p / 2]));	// Lane of the port
			default: return '0;
		endcase
	endfunction

	// One clock edge, model updated from the inputs held across it
	task automatic tick();
		regValT nxt;
		@(posedge clock);
		if (!rstN)
		begin
			for (int k = 0; k < 3; k++)
				refSpr[k] = '0;
		end
		else if (!hold && !ex3Flush)
		begin
			for (int k = 0; k < 3; k++)
			begin
				nxt = inSpr[k];
				for (int l = 0; l < numLanes; l++)
					if (exId[2][l] == sprCode[k])
						nxt = exVal[2][l];
				refSpr[k] = nxt;
			end
			for (int l = 0; l < numLanes; l++)
				if (!exId[2][l][5])
					refGpr[exId[2][l][4:0]] = exVal[2][l];	// Lane C applied last
		end
		#1;
	endtask

	task automatic compareOperand(input string name, input regValT got, input regValT exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "operand mismatch");
		end
	endtask

	task automatic compareSpecial(input string name, input regValT got, input regValT exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "special register mismatch");
		end
	endtask

	task automatic clearStages();
		for (int s = 0; s < 3; s++)
			for (int l = 0; l < numLanes; l++)
			begin
				exId[s][l] = idZzr;	// Idle lane
				exVal[s][l] = '0;
			end
	endtask

	task automatic setSources(input regIdT a, b, c, d, e, f);
		srcId[0] = a;
		srcId[1] = b;
		srcId[2] = c;
		srcId[3] = d;
		srcId[4] = e;
		srcId[5] = f;
	endtask

	task automatic checkPorts();
		#1;
		compareOperand("valRs", valRs, refRead(0));
		compareOperand("valRt", valRt, refRead(1));
		compareOperand("valRu", valRu, refRead(2));
		compareOperand("valRv", valRv, refRead(3));
		compareOperand("valRx", valRx, refRead(4));
		compareOperand("valRy", valRy, refRead(5));
	endtask

	task automatic checkSpecials();
		compareSpecial("outDlr", outDlr, refSpr[0]);
		compareSpecial("outDhr", outDhr, refSpr[1]);
		compareSpecial("outSp", outSp, refSpr[2]);
	endtask

	task automatic checkReset();
		setSources(idDlr, idDhr, idSp, idDlr, idDhr, idSp);
		checkPorts();
		compareSpecial("outDlr", outDlr, '0);
		compareSpecial("outDhr", outDhr, '0);
		compareSpecial("outSp", outSp, '0);
	endtask

	task automatic writeReadBack();
		for (int r = 0; r < numGprs; r++)
		begin
			clearStages();
			exId[2][r % numLanes] = regIdT'(r);	// Rotate through the lanes
			exVal[2][r % numLanes] = nextRand();
			tick();
		end
		clearStages();
		for (int r = 0; r < numGprs; r++)
		begin
			setSources(regIdT'(r), regIdT'(r), regIdT'(r), regIdT'(r), regIdT'(r), regIdT'(r));
			checkPorts();
			tick();
		end
	endtask

	task automatic laneConflicts();
		regValT want;
		for (int l = 0; l < numLanes; l++)
		begin
			exId[2][l] = 6'd5;
			exVal[2][l] = nextRand();
		end
		want = exVal[2][2];
		tick();
		clearStages();
		setSources(6'd5, 6'd5, 6'd5, 6'd5, 6'd5, 6'd5);
		checkPorts();
		compareOperand("valRs", valRs, want);
		exId[2][0] = 6'd9;	// A and B only
		exId[2][1] = 6'd9;
		exVal[2][0] = nextRand();
		exVal[2][1] = nextRand();
		want = exVal[2][1];
		tick();
		clearStages();
		setSources(6'd9, 6'd9, 6'd9, 6'd9, 6'd9, 6'd9);
		checkPorts();
		compareOperand("valRy", valRy, want);
	endtask

	task automatic forwardPriority();
		for (int s = 0; s < 3; s++)
			for (int l = 0; l < numLanes; l++)
			begin
				exId[s][l] = 6'd7;
				exVal[s][l] = nextRand();
			end
		setSources(6'd7, 6'd7, 6'd7, 6'd7, 6'd7, 6'd7);
		checkPorts();
		compareOperand("valRs", valRs, exVal[0][0]);
		tick();
		exId[0][0] = idZzr;
		checkPorts();
		compareOperand("valRt", valRt, exVal[0][1]);
		tick();
		exId[0][1] = idZzr;
		exId[0][2] = idZzr;
		checkPorts();
		compareOperand("valRu", valRu, exVal[1][0]);
		tick();
		for (int l = 0; l < numLanes; l++)
			exId[1][l] = idZzr;
		exId[2][0] = idZzr;
		exId[2][1] = idZzr;
		checkPorts();
		compareOperand("valRv", valRv, exVal[2][2]);
		tick();
		// Constant sources must not pick up matching stage IDs
		for (int l = 0; l < numLanes; l++)
		begin
			exId[0][l] = idImm;
			exId[1][l] = idZzr;
			exVal[0][l] = nextRand();
			exVal[1][l] = nextRand();
			imm[l] = immValT'(nextRand());
		end
		setSources(idImm, idZzr, idImm, idZzr, idImm, idZzr);
		checkPorts();
		compareOperand("valRt", valRt, '0);
	endtask

	task automatic specialRegs();
		tick();
		clearStages();
		for (int k = 0; k < 3; k++)
			inSpr[k] = nextRand();
		setSources(idDlr, idDhr, idSp, idSp, idDhr, idDlr);
		tick();
		checkPorts();
		checkSpecials();
		compareSpecial("outDhr", outDhr, inSpr[1]);
		exId[2][0] = idDlr;	// Write-back beats the inputs
		exId[2][1] = idSp;
		exId[2][2] = idSp;
		for (int l = 0; l < numLanes; l++)
			exVal[2][l] = nextRand();
		tick();
		compareSpecial("outSp", outSp, exVal[2][2]);
		clearStages();
		checkPorts();
		checkSpecials();
		for (int f = 0; f < 2; f++)
		begin
			hold = (f == 0);
			ex3Flush = (f == 1);
			inSpr[0] = nextRand();
			exId[2][0] = 6'd3;
			exVal[2][0] = nextRand();
			tick();
			tick();
			clearStages();
			setSources(6'd3, idDlr, idDhr, idSp, 6'd3, idDlr);
			checkPorts();
			checkSpecials();
			hold = 1'b0;
			ex3Flush = 1'b0;
		end
		tick();
		checkSpecials();
	endtask

	task automatic constantSources();
		regValT r;
		r = nextRand();
		pc = r[47:0];
		r = nextRand();
		gbr = r[47:0];
		r = nextRand();
		lr = r[47:0];
		r = nextRand();
		imm[0] = {1'b0, r[31:0]};
		imm[1] = {1'b0, r[63:32]};
		imm[2] = {1'b1, r[47:16]};	// Negative immediate
		setSources(idPc, idGbr, idLr, idImm, idImm, idZzr);
		checkPorts();
		compareOperand("valRs", valRs, {16'h0000, pc});
		compareOperand("valRx", valRx, {32'hFFFF_FFFF, imm[2][31:0]});
		tick();
		setSources(idImm, 6'h25, 6'h3A, idImm, 6'h2E, idZzr);
		checkPorts();
		compareOperand("valRu", valRu, '0);
	endtask

	initial
	begin
		rstN = 1'b0;
		hold = 1'b0;
		ex3Flush = 1'b0;
		pc = '0;
		gbr = '0;
		lr = '0;
		sprCode[0] = idDlr;
		sprCode[1] = idDhr;
		sprCode[2] = idSp;
		for (int k = 0; k < 3; k++)
		begin
			imm[k] = '0;
			inSpr[k] = nextRand();	// Nonzero, so reset clearing shows
			refSpr[k] = '0;
		end
		clearStages();
		setSources(idZzr, idZzr, idZzr, idZzr, idZzr, idZzr);
		repeat (5) tick();
		rstN = 1'b1;
		checkReset();
		writeReadBack();
		laneConflicts();
		forwardPriority();
		specialRegs();
		constantSources();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: logic/gprFile.sv
/*
  Operand register file top, six read ports and three write lanes
  - stage buses built from the plain pipeline ports
  - write enable from hold and EX3 flush
  - bank array, DLR/DHR/SP registers and the six operand ports
*/
`timescale 1ns/1ns

module gprFile(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic ex3Flush,

	input gprPkg::regIdT idRs,	// Lane A sources
	input gprPkg::regIdT idRt,
	input gprPkg::regIdT idRu,	// Lane B sources
	input gprPkg::regIdT idRv,
	input gprPkg::regIdT idRx,	// Lane C sources
	input gprPkg::regIdT idRy,
	output gprPkg::regValT valRs,
	output gprPkg::regValT valRt,
	output gprPkg::regValT valRu,
	output gprPkg::regValT valRv,
	output gprPkg::regValT valRx,
	output gprPkg::regValT valRy,

	input gprPkg::regIdT ex1IdA,
	input gprPkg::regIdT ex1IdB,
	input gprPkg::regIdT ex1IdC,
	input gprPkg::regValT ex1ValA,
	input gprPkg::regValT ex1ValB,
	input gprPkg::regValT ex1ValC,
	input gprPkg::regIdT ex2IdA,
	input gprPkg::regIdT ex2IdB,
	input gprPkg::regIdT ex2IdC,
	input gprPkg::regValT ex2ValA,
	input gprPkg::regValT ex2ValB,
	input gprPkg::regValT ex2ValC,
	input gprPkg::regIdT ex3IdA,	// Write-back stage
	input gprPkg::regIdT ex3IdB,
	input gprPkg::regIdT ex3IdC,
	input gprPkg::regValT ex3ValA,
	input gprPkg::regValT ex3ValB,
	input gprPkg::regValT ex3ValC,

	input gprPkg::addrValT pc,
	input gprPkg::addrValT gbr,
	input gprPkg::addrValT lr,
	input gprPkg::immValT immA,
	input gprPkg::immValT immB,
	input gprPkg::immValT immC,

	input gprPkg::regValT inDlr,
	input gprPkg::regValT inDhr,
	input gprPkg::regValT inSp,
	output gprPkg::regValT outDlr,
	output gprPkg::regValT outDhr,
	output gprPkg::regValT outSp
);
	import gprPkg::*;

	logic writeEn;
	regIdT srcId [numReadPorts];	// Port order Rs, Rt, Ru, Rv, Rx, Ry
	immValT srcImm [numReadPorts];
	regValT bankVal [numReadPorts];
	regValT portVal [numReadPorts];

	laneResultIf ex1Bus();
	laneResultIf ex2Bus();
	laneResultIf ex3Bus();

	assign ex1Bus.idA = ex1IdA;
	assign ex1Bus.idB = ex1IdB;
	assign ex1Bus.idC = ex1IdC;
	assign ex1Bus.valA = ex1ValA;
	assign ex1Bus.valB = ex1ValB;
	assign ex1Bus.valC = ex1ValC;
	assign ex2Bus.idA = ex2IdA;
	assign ex2Bus.idB = ex2IdB;
	assign ex2Bus.idC = ex2IdC;
	assign ex2Bus.valA = ex2ValA;
	assign ex2Bus.valB = ex2ValB;
	assign ex2Bus.valC = ex2ValC;
	assign ex3Bus.idA = ex3IdA;
	assign ex3Bus.idB = ex3IdB;
	assign ex3Bus.idC = ex3IdC;
	assign ex3Bus.valA = ex3ValA;
	assign ex3Bus.valB = ex3ValB;
	assign ex3Bus.valC = ex3ValC;

	// Hold or an EX3 flush freezes all register state
	assign writeEn = !hold && !ex3Flush;

	assign srcId[0] = idRs;
	assign srcId[1] = idRt;
	assign srcId[2] = idRu;
	assign srcId[3] = idRv;
	assign srcId[4] = idRx;
	assign srcId[5] = idRy;

	// Each lane's sources see that lane's immediate
	assign srcImm[0] = immA;
	assign srcImm[1] = immA;
	assign srcImm[2] = immB;
	assign srcImm[3] = immB;
	assign srcImm[4] = immC;
	assign srcImm[5] = immC;

	gprBankArray bankArray(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.wb(ex3Bus),
		.rdId0(srcId[0][4:0]),
		.rdId1(srcId[1][4:0]),
		.rdId2(srcId[2][4:0]),
		.rdId3(srcId[3][4:0]),
		.rdId4(srcId[4][4:0]),
		.rdId5(srcId[5][4:0]),
		.rdVal0(bankVal[0]),
		.rdVal1(bankVal[1]),
		.rdVal2(bankVal[2]),
		.rdVal3(bankVal[3]),
		.rdVal4(bankVal[4]),
		.rdVal5(bankVal[5])
	);

	sprRegister #(.sprId(idDlr)) sprDlr(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.wb(ex3Bus),
		.extIn(inDlr),
		.value(outDlr)
	);

	sprRegister #(.sprId(idDhr)) sprDhr(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.wb(ex3Bus),
		.extIn(inDhr),
		.value(outDhr)
	);

	sprRegister #(.sprId(idSp)) sprSp(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.wb(ex3Bus),
		.extIn(inSp),
		.value(outSp)
	);

	for (genvar i = 0; i < numReadPorts; i++)
	begin : portGen
		operandPort readPort(
			.srcId(srcId[i]),
			.bankVal(bankVal[i]),
			.dlr(outDlr),
			.dhr(outDhr),
			.sp(outSp),
			.pc(pc),
			.gbr(gbr),
			.lr(lr),
			.imm(srcImm[i]),
			.ex1(ex1Bus),
			.ex2(ex2Bus),
			.ex3(ex3Bus),
			.value(portVal[i])
		);
	end

	assign valRs = portVal[0];
	assign valRt = portVal[1];
	assign valRu = portVal[2];
	assign valRv = portVal[3];
	assign valRx = portVal[4];
	assign valRy = portVal[5];

endmodule

// File: logic/operandPort.sv
/*
  One source operand read port
  - decodes the source ID into GPR, special, control or constant value
  - forwards EX1, EX2 and EX3 results, newest stage first
*/
`timescale 1ns/1ns

module operandPort(
	input gprPkg::regIdT srcId,
	input gprPkg::regValT bankVal,
	input gprPkg::regValT dlr,
	input gprPkg::regValT dhr,
	input gprPkg::regValT sp,
	input gprPkg::addrValT pc,
	input gprPkg::addrValT gbr,
	input gprPkg::addrValT lr,
	input gprPkg::immValT imm,
	laneResultIf.consumer ex1,
	laneResultIf.consumer ex2,
	laneResultIf.consumer ex3,
	output gprPkg::regValT value
);
	import gprPkg::*;

	regValT baseVal;	// Decoded value before forwarding
	logic noForward;

	// Match within one stage, lane A ahead of B ahead of C
	function automatic regValT pickStage(
		input regIdT src,
		input regValT cur,
		input regIdT idA,
		input regValT valA,
		input regIdT idB,
		input regValT valB,
		input regIdT idC,
		input regValT valC
	);
		regValT res;

		res = cur;
		if (src == idC)
			res = valC;
		if (src == idB)
			res = valB;
		if (src == idA)
			res = valA;
		return res;
	endfunction

	always_comb
	begin
		noForward = 1'b0;
		casez (srcId)
			6'b0?????:
				baseVal = bankVal;
			idDlr:
				baseVal = dlr;
			idDhr:
				baseVal = dhr;
			idSp:
				baseVal = sp;
			idPc:
				baseVal = {16'h0000, pc};
			idGbr:
				baseVal = {16'h0000, gbr};
			idLr:
				baseVal = {16'h0000, lr};
			idImm:
			begin
				baseVal = {{31{imm[32]}}, imm};	// Sign from bit 32
				noForward = 1'b1;
			end
			idZzr:
			begin
				baseVal = '0;
				noForward = 1'b1;
			end
			default:
				baseVal = '0;	// Unassigned IDs
		endcase
	end

	// Oldest stage first so that EX1 is applied last
	always_comb
	begin
		value = baseVal;
		if (!noForward)
		begin
			value = pickStage(srcId, value,
				ex3.idA, ex3.valA, ex3.idB, ex3.valB, ex3.idC, ex3.valC);
			value = pickStage(srcId, value,
				ex2.idA, ex2.valA, ex2.idB, ex2.valB, ex2.idC, ex2.valC);
			value = pickStage(srcId, value,
				ex1.idA, ex1.valA, ex1.idB, ex1.valB, ex1.idC, ex1.valC);
		end
	end

endmodule

// File: logic/sprRegister.sv
/*
  Single special register (DLR, DHR or SP)
  - loads a matching EX3 lane result
  - otherwise follows its external input
*/
`timescale 1ns/1ns

module sprRegister #(
	parameter gprPkg::regIdT sprId = gprPkg::idDlr
)(
	input logic clock,
	input logic rstN,
	input logic writeEn,
	laneResultIf.consumer wb,
	input gprPkg::regValT extIn,
	output gprPkg::regValT value
);
	import gprPkg::*;

	regValT nextVal;

	always_comb
	begin
		nextVal = extIn;	// No lane names this register
		if (wb.idA == sprId)
			nextVal = wb.valA;
		if (wb.idB == sprId)
			nextVal = wb.valB;
		if (wb.idC == sprId)
			nextVal = wb.valC;	// Last lane wins
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			value <= '0;
		else if (writeEn)
			value <= nextVal;
	end

endmodule

// File: logic/gprBankArray.sv
/*
  GPR storage with one bank per write lane
  - EX3 write-back into the lane's own bank
  - live-value table picking the newest bank per register
  - six combinational raw read ports
*/
`timescale 1ns/1ns

module gprBankArray(
	input logic clock,
	input logic rstN,
	input logic writeEn,
	laneResultIf.consumer wb,
	input gprPkg::gprIndexT rdId0,
	input gprPkg::gprIndexT rdId1,
	input gprPkg::gprIndexT rdId2,
	input gprPkg::gprIndexT rdId3,
	input gprPkg::gprIndexT rdId4,
	input gprPkg::gprIndexT rdId5,
	output gprPkg::regValT rdVal0,
	output gprPkg::regValT rdVal1,
	output gprPkg::regValT rdVal2,
	output gprPkg::regValT rdVal3,
	output gprPkg::regValT rdVal4,
	output gprPkg::regValT rdVal5
);
	import gprPkg::*;

	regValT bank [numLanes][numGprs];	// One bank per lane
	liveBankT liveTab [numGprs];

	// Each lane only ever writes its own bank, so no write port is shared
	always_ff @(posedge clock)
	begin
		if (writeEn)
		begin
			if (!wb.idA[5])
				bank[bankA][wb.idA[4:0]] <= wb.valA;
			if (!wb.idB[5])
				bank[bankB][wb.idB[4:0]] <= wb.valB;
			if (!wb.idC[5])
				bank[bankC][wb.idC[4:0]] <= wb.valC;
		end
	end

	// Later lane overrides on a same-cycle conflict
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < numGprs; i++)
				liveTab[i] <= bankA;
		end
		else if (writeEn)
		begin
			if (!wb.idA[5])
				liveTab[wb.idA[4:0]] <= bankA;
			if (!wb.idB[5])
				liveTab[wb.idB[4:0]] <= bankB;
			if (!wb.idC[5])
				liveTab[wb.idC[4:0]] <= bankC;	// C wins over B and A
		end
	end

	// Raw reads, no forwarding here
	assign rdVal0 = bank[liveTab[rdId0]][rdId0];
	assign rdVal1 = bank[liveTab[rdId1]][rdId1];
	assign rdVal2 = bank[liveTab[rdId2]][rdId2];
	assign rdVal3 = bank[liveTab[rdId3]][rdId3];
	assign rdVal4 = bank[liveTab[rdId4]][rdId4];
	assign rdVal5 = bank[liveTab[rdId5]][rdId5];

endmodule

// File: logic/laneResultIf.sv
/*
  Results of the three issue lanes in one pipeline stage
  - destination ID and value per lane
  - producer and consumer views
*/
`timescale 1ns/1ns

interface laneResultIf;
	import gprPkg::*;

	regIdT idA;	// Lane A destination
	regIdT idB;
	regIdT idC;
	regValT valA;
	regValT valB;
	regValT valC;

	modport producer(
		output idA, idB, idC,
		output valA, valB, valC
	);

	modport consumer(
		input idA, idB, idC,
		input valA, valB, valC
	);

endinterface

// File: logic/gprPkg.sv
/*
  Shared definitions for the operand register file
  - register ID, value, immediate and address types
  - register count, lane count and read port count
  - live-value table bank codes
  - special and pseudo register ID codes
*/
package gprPkg;

	localparam int numGprs = 32;
	localparam int numLanes = 3;
	localparam int numReadPorts = 2 * numLanes;	// Two sources per issue lane

	typedef logic [5:0] regIdT;	// Bit 5 clear selects a GPR
	typedef logic [63:0] regValT;
	typedef logic [32:0] immValT;	// Bit 32 is the sign
	typedef logic [47:0] addrValT;	// PC, GBR, LR width
	typedef logic [$clog2(numGprs)-1:0] gprIndexT;

	// Which write bank holds the newest copy
	typedef logic [$clog2(numLanes)-1:0] liveBankT;

	localparam liveBankT bankA = 2'd0;
	localparam liveBankT bankB = 2'd1;
	localparam liveBankT bankC = 2'd2;

	// Special registers, backed by real storage
	localparam regIdT idDlr = 6'h20;
	localparam regIdT idDhr = 6'h21;
	localparam regIdT idSp = 6'h2F;

	// Control registers, read zero-extended
	localparam regIdT idPc = 6'h30;
	localparam regIdT idGbr = 6'h31;
	localparam regIdT idLr = 6'h32;

	// Constant sources, never forwarded
	localparam regIdT idImm = 6'h3E;
	localparam regIdT idZzr = 6'h3F;

endpackage
